// File: logic/hyper_wdata_pkg.sv
////////////////////////////////////////////////////////////
// HyperBus write-data path shared definitions
// Widths, AXI size codes and the byte-lane view of a word
////////////////////////////////////////////////////////////

package hyper_wdata_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned LSB_W  = $clog2(STRB_W);  // Byte address inside one word
  localparam int unsigned LEN_W  = 8;               // Beats minus one, as on AXI
  localparam int unsigned SIZE_W = 3;

  ////////////////////////////////////////////////////////////
  // AXI size codes
  ////////////////////////////////////////////////////////////

  localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 3'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;

  ////////////////////////////////////////////////////////////
  // Data word
  ////////////////////////////////////////////////////////////

  // The upsizer places bytes by lane, everything else moves whole words
  typedef union packed {
    logic [DATA_W-1:0]            word;
    logic [STRB_W-1:0][7:0]       lanes;
  } hyper_word_u;

endpackage

// File: logic/hyper_aw_tracker.sv
////////////////////////////////////////////////////////////
// Write command tracker
// Holds one burst at a time and opens the W channel for it
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hyper_aw_tracker
  import hyper_wdata_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              aw_valid_i,
  input  logic [SIZE_W-1:0] aw_size_i,
  input  logic [LSB_W-1:0]  aw_addr_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  output logic              aw_ready_o,
  input  logic              w_xfer_last_i,
  output logic              burst_start_o,
  output logic [SIZE_W-1:0] burst_size_o,
  output logic [LSB_W-1:0]  burst_addr_o,
  output logic [LEN_W-1:0]  burst_len_o,
  output logic              w_open_o
);

  typedef enum logic {Idle, Open} aw_state_e;

  aw_state_e state_q;
  logic      aw_xfer;

  assign aw_ready_o = (state_q == Idle);
  assign aw_xfer    = aw_valid_i & aw_ready_o;
  assign w_open_o   = (state_q == Open);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      burst_start_o <= 1'b0;
    end else begin
      burst_start_o <= aw_xfer;  // One cycle after the accept
      if (aw_xfer) begin
        state_q <= Open;
      end else if (w_xfer_last_i) begin
        state_q <= Idle;
      end
    end
  end

  // Command fields stay put until the next accept
  always_ff @(posedge clk_i) begin
    if (aw_xfer) begin
      burst_size_o <= aw_size_i;
      burst_addr_o <= aw_addr_i;
      burst_len_o  <= aw_len_i;
    end
  end

  // Nothing wider than the data bus enters this path
  a_size_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i |-> aw_size_i <= SIZE_WORD);

  // Full-width bursts are never split, so they must start on a word
  a_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && aw_size_i == SIZE_WORD |-> aw_addr_i == '0);

endmodule

// File: logic/hyper_upsizer.sv
////////////////////////////////////////////////////////////
// Write upsizer
// Packs 8 and 16 bit beats into full words with byte strobes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hyper_upsizer
  import hyper_wdata_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [SIZE_W-1:0] size_i,
  input  logic [LSB_W-1:0]  start_addr_i,
  input  logic              trans_start_i,
  input  logic              valid_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic [STRB_W-1:0] strb_i,
  input  logic              last_i,
  output logic              ready_o,
  output logic              sel_o,
  output logic              valid_o,
  output logic [DATA_W-1:0] data_o,
  output logic [STRB_W-1:0] strb_o,
  output logic              last_o,
  input  logic              ready_i
);

  typedef enum logic [1:0] {
    Idle,
    Sample,
    WaitReady,
    WaitNextTrans
  } up_state_e;

  up_state_e         state_q, state_d;
  hyper_word_u       beat_w;
  hyper_word_u       word_q, word_d;
  logic [STRB_W-1:0] strb_q, strb_d;
  logic              last_q, last_d;
  logic [LSB_W-1:0]  idx_q, idx_d;
  logic              pend_q, pend_d;

  logic              narrow;
  logic              beat;
  logic              handoff;
  logic [LSB_W:0]    beat_bytes;
  logic [LSB_W:0]    idx_end;    // One past the last lane this beat fills
  logic              go;

  assign beat_w.word = data_i;

  assign narrow     = (size_i != SIZE_WORD);
  assign beat       = valid_i & ready_o;
  assign handoff    = valid_o & ready_i;
  assign beat_bytes = (LSB_W+1)'(1) << size_i;
  assign idx_end    = {1'b0, idx_q} + beat_bytes;
  assign go         = trans_start_i | pend_q;

  // While a word waits for the buffer the W beats stay parked on this side
  assign sel_o   = (state_q == WaitReady) | narrow;
  assign ready_o = (state_q == Sample);
  assign valid_o = (state_q == WaitReady);
  assign data_o  = word_q.word;
  assign strb_o  = strb_q;
  assign last_o  = last_q;

  ////////////////////////////////////////////////////////////
  // Packing
  ////////////////////////////////////////////////////////////

  always_comb begin
    word_d = word_q;
    strb_d = strb_q;
    last_d = last_q;
    idx_d  = idx_q;
    if (handoff) begin
      word_d = '0;  // Unwritten lanes of the next word read as zero
      strb_d = '0;
      last_d = 1'b0;
    end else if (beat) begin
      for (int k = 0; k < STRB_W; k++) begin
        if (k >= idx_q && k < idx_end) begin
          word_d.lanes[k] = beat_w.lanes[k];
          strb_d[k]       = strb_i[k];
        end
      end
      last_d = last_i;
    end
    if (trans_start_i) begin
      idx_d = start_addr_i;
    end else if (beat) begin
      idx_d = idx_end[LSB_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    pend_d  = pend_q;
    case (state_q)
      Idle, WaitNextTrans: begin
        if (trans_start_i) begin
          state_d = narrow ? Sample : Idle;
        end
      end
      Sample: begin
        // Emit on a filled lane 3 or on the closing beat
        if (beat && (idx_end[LSB_W] || last_i)) begin
          state_d = WaitReady;
        end
      end
      WaitReady: begin
        if (trans_start_i) pend_d = 1'b1;  // Next command came in early
        if (ready_i) begin
          if (!last_q) begin
            state_d = Sample;
          end else if (go) begin
            state_d = narrow ? Sample : Idle;
            pend_d  = 1'b0;
          end else begin
            state_d = WaitNextTrans;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      pend_q  <= 1'b0;
      idx_q   <= '0;
      word_q  <= '0;
      strb_q  <= '0;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      pend_q  <= pend_d;
      idx_q   <= idx_d;
      word_q  <= word_d;
      strb_q  <= strb_d;
      last_q  <= last_d;
    end
  end

  // The next burst only starts once the closing beat has left Sample
  a_start_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_start_i |-> state_q != Sample);

  // Halfword beats sit on even addresses
  a_beat_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat && size_i == SIZE_HALF |-> !idx_q[0]);

endmodule

// File: logic/hyper_wdata_steer.sv
////////////////////////////////////////////////////////////
// Write beat steering
// Routes beats through the upsizer or past it to the buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hyper_wdata_steer
  import hyper_wdata_pkg::*;
(
  input  logic              sel_i,
  input  logic              w_valid_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,
  output logic              up_valid_o,
  input  logic              up_ready_i,
  input  logic              up_word_valid_i,
  input  logic [DATA_W-1:0] up_word_data_i,
  input  logic [STRB_W-1:0] up_word_strb_i,
  input  logic              up_word_last_i,
  output logic              up_word_ready_o,
  output logic              buf_valid_o,
  output logic [DATA_W-1:0] buf_data_o,
  output logic [STRB_W-1:0] buf_strb_o,
  output logic              buf_last_o,
  input  logic              buf_ready_i
);

  hyper_word_u beat_w;
  hyper_word_u up_w;

  assign beat_w.word = w_data_i;
  assign up_w.word   = up_word_data_i;

  // Beat side
  assign up_valid_o = sel_i & w_valid_i;
  assign w_ready_o  = sel_i ? up_ready_i : buf_ready_i;

  // Buffer side
  assign buf_valid_o     = sel_i ? up_word_valid_i : w_valid_i;
  assign buf_data_o      = sel_i ? up_w.word : beat_w.word;
  assign buf_strb_o      = sel_i ? up_word_strb_i : w_strb_i;
  assign buf_last_o      = sel_i ? up_word_last_i : w_last_i;
  assign up_word_ready_o = sel_i & buf_ready_i;

  // The upsizer keeps its select while it still owns a word, else that word and a
  // bypass beat would race for the buffer
  always_comb begin
    a_no_double_offer: assert final (!(up_word_valid_i && !sel_i));
  end

endmodule

// File: logic/hyper_word_buf.sv
////////////////////////////////////////////////////////////
// Two-entry word FIFO toward the HyperBus PHY
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hyper_word_buf
  import hyper_wdata_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,
  input  logic [DATA_W-1:0] in_data_i,
  input  logic [STRB_W-1:0] in_strb_i,
  input  logic              in_last_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  output logic [STRB_W-1:0] out_strb_o,
  output logic              out_last_o,
  input  logic              out_ready_i
);

  logic [1:0][DATA_W-1:0] data_q;
  logic [1:0][STRB_W-1:0] strb_q;
  logic [1:0]             last_q;
  logic                   wr_ptr_q, rd_ptr_q;
  logic [1:0]             count_q;
  logic                   wr_en, rd_en;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign wr_en       = in_valid_i & in_ready_o;
  assign rd_en       = out_valid_o & out_ready_i;

  assign out_data_o = data_q[rd_ptr_q];
  assign out_strb_o = strb_q[rd_ptr_q];
  assign out_last_o = last_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (wr_en) wr_ptr_q <= ~wr_ptr_q;
      if (rd_en) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(wr_en) - 2'(rd_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      data_q[wr_ptr_q] <= in_data_i;
      strb_q[wr_ptr_q] <= in_strb_i;
      last_q[wr_ptr_q] <= in_last_i;
    end
  end

  // A word held off by a full buffer waits unchanged at the input
  a_full_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i) && $stable(in_strb_i)
                                  && $stable(in_last_i));

endmodule

// File: logic/hyper_wdata_top.sv
////////////////////////////////////////////////////////////
// HyperBus write-data path
// Command tracker, beat steering, upsizer and PHY word buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hyper_wdata_top
  import hyper_wdata_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              aw_valid_i,
  input  logic [SIZE_W-1:0] aw_size_i,
  input  logic [LSB_W-1:0]  aw_addr_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  output logic              aw_ready_o,
  input  logic              w_valid_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,
  output logic              phy_valid_o,
  output logic [DATA_W-1:0] phy_data_o,
  output logic [STRB_W-1:0] phy_strb_o,
  output logic              phy_last_o,
  input  logic              phy_ready_i
);

  logic              burst_start, w_open, w_xfer_last;
  logic [SIZE_W-1:0] burst_size;
  logic [LSB_W-1:0]  burst_addr;
  logic              w_valid_open, steer_w_ready, sel;
  logic              up_valid, up_ready;
  logic              up_word_valid, up_word_last, up_word_ready;
  logic [DATA_W-1:0] up_word_data;
  logic [STRB_W-1:0] up_word_strb;
  logic              buf_valid, buf_last, buf_ready;
  logic [DATA_W-1:0] buf_data;
  logic [STRB_W-1:0] buf_strb;

  // Beats only count while a burst is open
  assign w_valid_open = w_valid_i & w_open;
  assign w_ready_o    = steer_w_ready & w_open;
  assign w_xfer_last  = w_valid_i & w_ready_o & w_last_i;

  // The burst length is not needed downstream, beats end on w_last_i
  hyper_aw_tracker u_tracker (
    .clk_i, .rst_ni,
    .aw_valid_i, .aw_size_i, .aw_addr_i, .aw_len_i, .aw_ready_o,
    .w_xfer_last_i (w_xfer_last),
    .burst_start_o (burst_start),
    .burst_size_o  (burst_size),
    .burst_addr_o  (burst_addr),
    .burst_len_o   (),
    .w_open_o      (w_open)
  );

  hyper_wdata_steer u_steer (
    .sel_i (sel),
    .w_valid_i (w_valid_open), .w_data_i, .w_strb_i, .w_last_i,
    .w_ready_o (steer_w_ready),
    .up_valid_o (up_valid), .up_ready_i (up_ready),
    .up_word_valid_i (up_word_valid), .up_word_data_i (up_word_data),
    .up_word_strb_i (up_word_strb), .up_word_last_i (up_word_last),
    .up_word_ready_o (up_word_ready),
    .buf_valid_o (buf_valid), .buf_data_o (buf_data), .buf_strb_o (buf_strb),
    .buf_last_o (buf_last), .buf_ready_i (buf_ready)
  );

  hyper_upsizer u_upsizer (
    .clk_i, .rst_ni,
    .size_i (burst_size), .start_addr_i (burst_addr), .trans_start_i (burst_start),
    .valid_i (up_valid), .data_i (w_data_i), .strb_i (w_strb_i), .last_i (w_last_i),
    .ready_o (up_ready), .sel_o (sel),
    .valid_o (up_word_valid), .data_o (up_word_data), .strb_o (up_word_strb),
    .last_o (up_word_last), .ready_i (up_word_ready)
  );

  hyper_word_buf u_word_buf (
    .clk_i, .rst_ni,
    .in_valid_i (buf_valid), .in_data_i (buf_data), .in_strb_i (buf_strb),
    .in_last_i (buf_last), .in_ready_o (buf_ready),
    .out_valid_o (phy_valid_o), .out_data_o (phy_data_o), .out_strb_o (phy_strb_o),
    .out_last_o (phy_last_o), .out_ready_i (phy_ready_i)
  );

endmodule

// File: bench/tb_hyper_wdata_tests.svh
////////////////////////////////////////////////////////////
// Directed tests for the HyperBus write-data path
////////////////////////////////////////////////////////////

  task automatic test_wide_passthrough();
    int e0;
    e0 = errors;
    rx_sl.delete();
    check_flag(phy_valid_o, 1'b0, "phy_valid_o after reset");
    check_flag(w_ready_o, 1'b0, "w_ready_o after reset");
    check_flag(aw_ready_o, 1'b1, "aw_ready_o after reset");
    gen_burst(SIZE_WORD, 2'd0, 4);
    run_bursts();
    drain();
    check_count(4);
    report("wide pass-through", e0);
  endtask

  task automatic test_byte_aligned();
    int e0;
    e0 = errors;
    rx_sl.delete();
    gen_burst(SIZE_BYTE, 2'd0, 8);
    run_bursts();
    drain();
    check_count(2);
    check_strb_last(rx_sl[0], 5'b1111_0, "first word strobe and last");
    check_strb_last(rx_sl[1], 5'b1111_1, "second word strobe and last");
    report("byte burst from lane 0", e0);
  endtask

  // Four halfwords from lane 2 end on lane 1, so both ends of the burst are partial
  task automatic test_half_misaligned();
    int e0;
    e0 = errors;
    rx_sl.delete();
    gen_burst(SIZE_HALF, 2'd2, 4);
    run_bursts();
    drain();
    check_count(3);
    check_strb_last(rx_sl[0], 5'b1100_0, "first word strobe and last");
    check_strb_last(rx_sl[1], 5'b1111_0, "second word strobe and last");
    check_strb_last(rx_sl[2], 5'b0011_1, "third word strobe and last");
    report("halfword burst from lane 2", e0);
  endtask

  task automatic test_byte_masks();
    int e0;
    e0 = errors;
    rx_sl.delete();
    gen_burst(SIZE_BYTE, 2'd3, 2);
    run_bursts();
    drain();
    check_count(2);
    check_strb_last(rx_sl[0], 5'b1000_0, "start mask word");
    check_strb_last(rx_sl[1], 5'b0001_1, "end mask word");
    report("byte burst from lane 3", e0);
  endtask

  task automatic test_backpressure();
    int                e0;
    logic [SIZE_W-1:0] size;
    logic [LSB_W-1:0]  addr;
    e0 = errors;
    rx_sl.delete();
    bp_en <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      size = SIZE_W'($urandom_range(2, 0));
      addr = LSB_W'($urandom_range(3, 0)) & ~LSB_W'((1 << size) - 1);
      gen_burst(size, addr, int'($urandom_range(8, 1)));
    end
    run_bursts();
    drain();
    bp_en <= 1'b0;
    report("random back-pressure", e0);
  endtask

  // A narrow burst, then a wide one while the last narrow word may still be pending
  task automatic test_back_to_back();
    int e0;
    e0 = errors;
    rx_sl.delete();
    gen_burst(SIZE_BYTE, 2'd1, 6);
    gen_burst(SIZE_WORD, 2'd0, 3);
    gen_burst(SIZE_HALF, 2'd2, 2);
    run_bursts();
    drain();
    check_count(7);
    report("back-to-back commands", e0);
  endtask

// File: bench/tb_hyper_wdata.sv
////////////////////////////////////////////////////////////
// Testbench for the HyperBus write-data path
// Directed bursts against a packing model with PHY stalls
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_hyper_wdata
  import hyper_wdata_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int BEAT_BUDGET = 100;  // Beats over all tests, rounded up
  localparam int TIMEOUT_NS  = (BEAT_BUDGET * 20 + 200) * CLK_PERIOD;

  logic              clk_i, rst_ni;
  logic              aw_valid_i, aw_ready_o;
  logic [SIZE_W-1:0] aw_size_i;
  logic [LSB_W-1:0]  aw_addr_i;
  logic [LEN_W-1:0]  aw_len_i;
  logic              w_valid_i, w_last_i, w_ready_o;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              phy_valid_o, phy_last_o, phy_ready_i;
  logic [DATA_W-1:0] phy_data_o;
  logic [STRB_W-1:0] phy_strb_o;

  logic bp_en;
  int   errors, tests_run, tests_failed, lasts_sent;

  // Commands and beats waiting to be driven
  logic [SIZE_W-1:0] cq_size[$];
  logic [LSB_W-1:0]  cq_addr[$];
  logic [LEN_W-1:0]  cq_len[$];
  logic [DATA_W-1:0] bq_data[$];
  logic [STRB_W-1:0] bq_strb[$];
  logic              bq_last[$];

  // Expected words, and the strobe/last pairs that reached the PHY
  hyper_word_u       exp_data[$];
  logic [STRB_W:0]   exp_sl[$];
  logic [STRB_W:0]   rx_sl[$];
  hyper_word_u       mon_word;

  hyper_wdata_top dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input hyper_word_u got, input hyper_word_u exp, input string what);
    if (got !== exp) begin
      $display("Error @ %0t ns: %s is %h, expected %h", $time, what, got.word, exp.word);
      errors++;
    end
  endtask

  task automatic check_strb_last(input logic [STRB_W:0] got, input logic [STRB_W:0] exp,
                                 input string what);
    if (got !== exp) begin
      $display("Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int n);
    if (rx_sl.size() != n) begin
      $display("Error @ %0t ns: %0d words reached the PHY, expected %0d", $time, rx_sl.size(), n);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // PHY side
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    phy_ready_i <= bp_en ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  always @(posedge clk_i) begin
    if (rst_ni && phy_valid_o && phy_ready_i) begin
      mon_word.word = phy_data_o;
      rx_sl.push_back({phy_strb_o, phy_last_o});
      if (exp_data.size() == 0) begin
        $display("Error @ %0t ns: unexpected word %h on the PHY side", $time, phy_data_o);
        errors++;
      end else begin
        check_word(mon_word, exp_data.pop_front(), "PHY data");
        check_strb_last({phy_strb_o, phy_last_o}, exp_sl.pop_front(), "PHY strobe and last");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////

  // Each beat fills its lanes from the running byte index. A word closes when lane 3
  // is filled or on the last beat, and lanes it never got stay zero with strobe 0
  task automatic gen_burst(input logic [SIZE_W-1:0] size, input logic [LSB_W-1:0] addr,
                           input int n);
    hyper_word_u       w, b;
    logic [STRB_W-1:0] s, bs;
    logic              last;
    int                idx, nb;
    nb  = 1 << size;
    idx = int'(addr);
    w   = '0;
    s   = '0;
    cq_size.push_back(size);
    cq_addr.push_back(addr);
    cq_len.push_back(LEN_W'(n - 1));
    for (int i = 0; i < n; i++) begin
      b.word = $urandom();
      last   = (i == n - 1);
      if (size == SIZE_WORD) bs = STRB_W'($urandom());  // Any pattern is legal at full width
      else bs = STRB_W'(((1 << nb) - 1) << idx);
      bq_data.push_back(b.word);
      bq_strb.push_back(bs);
      bq_last.push_back(last);
      for (int k = idx; k < idx + nb; k++) begin
        w.lanes[k] = b.lanes[k];
        s[k]       = bs[k];
      end
      idx += nb;
      if (idx == STRB_W || last) begin
        exp_data.push_back(w);
        exp_sl.push_back({s, last});
        w   = '0;
        s   = '0;
        idx = idx % STRB_W;
      end
    end
  endtask

  // Commands and beats run side by side, beats are offered before their command
  task automatic run_bursts();
    int k;
    k          = 0;
    lasts_sent = 0;
    fork
      begin
        while (cq_size.size() != 0) begin
          aw_valid_i <= 1'b1;
          aw_size_i  <= cq_size.pop_front();
          aw_addr_i  <= cq_addr.pop_front();
          aw_len_i   <= cq_len.pop_front();
          @(posedge clk_i);
          while (!aw_ready_o) @(posedge clk_i);
          if (lasts_sent != k) begin
            $display("Error @ %0t ns: command %0d accepted after %0d closed bursts",
                     $time, k, lasts_sent);
            errors++;
          end
          k++;
        end
        aw_valid_i <= 1'b0;
      end
      begin
        while (bq_data.size() != 0) begin
          w_valid_i <= 1'b1;
          w_data_i  <= bq_data.pop_front();
          w_strb_i  <= bq_strb.pop_front();
          w_last_i  <= bq_last.pop_front();
          @(posedge clk_i);
          while (!w_ready_o) @(posedge clk_i);
          if (w_last_i) lasts_sent++;
        end
        w_valid_i <= 1'b0;
        w_last_i  <= 1'b0;
      end
    join
  endtask

  task automatic drain();
    while (exp_data.size() != 0) @(posedge clk_i);
    repeat (8) @(posedge clk_i);  // Room for a stray extra word to show up
  endtask

  task automatic report(input string name, input int e0);
    tests_run++;
    if (errors != e0) tests_failed++;
    $display("%-28s %s", name, (errors == e0) ? "passed" : "failed");
  endtask

  `include "tb_hyper_wdata_tests.svh"

  initial begin
    void'($urandom(24777));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    aw_valid_i   = 1'b0;
    aw_size_i    = '0;
    aw_addr_i    = '0;
    aw_len_i     = '0;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    w_strb_i     = '0;
    w_last_i     = 1'b0;
    phy_ready_i  = 1'b1;
    bp_en        = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lasts_sent   = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_wide_passthrough();
    test_byte_aligned();
    test_half_misaligned();
    test_byte_masks();
    test_backpressure();
    test_back_to_back();
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
logic/hyper_wdata_pkg.sv
logic/hyper_aw_tracker.sv
logic/hyper_upsizer.sv
logic/hyper_wdata_steer.sv
logic/hyper_word_buf.sv
logic/hyper_wdata_top.sv
bench/tb_hyper_wdata.sv

// File: Makefile
# Verilator build and run of the HyperBus write-data testbench

TOP := tb_hyper_wdata

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f logic/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || (echo "No pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
